/* common/lc3_pkg.sv */
package lc3_pkg;

    localparam int word_width = 16;

    typedef logic [word_width-1:0] word_t;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add    = 2'b00,
        alu_and    = 2'b01,
        alu_not    = 2'b10,
        alu_pass_b = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        pc_inc = 2'b00,
        pc_reg = 2'b01,
        pc_alu = 2'b11
    } pcmux_t;

    typedef enum logic [2:0] {
        b_reg   = 3'b000,
        b_imm5  = 3'b001,
        b_off9  = 3'b010,
        b_off11 = 3'b011,
        b_off6  = 3'b100
    } alumux2_t;

    typedef enum logic [3:0] {
        s_fetch1   = 4'd0,
        s_fetch2   = 4'd1,
        s_fetch3   = 4'd2,
        s_decode   = 4'd3,
        s_alu      = 4'd4,
        s_lea      = 4'd5,
        s_br       = 4'd6,
        s_jmp      = 4'd7,
        s_ld_addr  = 4'd8,
        s_ld_read  = 4'd9,
        s_ld_wb    = 4'd10,
        s_st_addr  = 4'd11,
        s_st_mdr   = 4'd12,
        s_st_write = 4'd13,
        s_halt     = 4'd14
    } state_t;

endpackage

/* datapath/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ld_regf,
    input  lc3_pkg::word_t      in,
    input  logic [2:0]          dr,
    input  logic [2:0]          sr1,
    input  logic [2:0]          sr2,
    output lc3_pkg::word_t      ra,
    output lc3_pkg::word_t      rb
);

    lc3_pkg::word_t regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ld_regf) begin
            regs[dr] <= in;
        end
    end

    // reads are combinational so the ALU sees operands in the same cycle.
    assign ra = regs[sr1];
    assign rb = regs[sr2];

endmodule

/* datapath/alu.sv */
`timescale 1ns/1ps

module alu (
    input  lc3_pkg::alu_op_t op,
    input  lc3_pkg::word_t   a,
    input  lc3_pkg::word_t   b,
    output lc3_pkg::word_t   f
);

    always_comb begin
        case (op)
            lc3_pkg::alu_add: begin
                f = a + b; // carry out is dropped, LC-3 has no carry flag.
            end
            lc3_pkg::alu_and: begin
                f = a & b;
            end
            lc3_pkg::alu_not: begin
                f = ~a;
            end
            lc3_pkg::alu_pass_b: begin
                f = b;
            end
            default: begin
                f = b;
            end
        endcase
    end

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter lc3_pkg::word_t reset_vector = 16'h3000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ld_pc,
    input  logic                ld_ir,
    input  logic                ld_regf,
    input  logic                ld_mdr,
    input  logic                ld_mar,
    input  logic                ld_nzp,
    input  logic                mdr_sel,
    input  lc3_pkg::pcmux_t     pcmux_sel,
    input  logic                regfilemux_sel,
    input  logic                marmux_sel,
    input  logic                alumux1_sel,
    input  lc3_pkg::alumux2_t   alumux2_sel,
    input  lc3_pkg::alu_op_t    alu_op,
    input  lc3_pkg::word_t      mdr_in,
    output lc3_pkg::opcode_t    opcode,
    output logic                ir_bit5,
    output logic                ben,
    output lc3_pkg::word_t      mar,
    output lc3_pkg::word_t      mdr
);

    lc3_pkg::word_t pc_q;
    lc3_pkg::word_t ir_q;
    lc3_pkg::word_t mar_q;
    lc3_pkg::word_t mdr_q;
    logic [2:0]     nzp_q;

    logic [2:0]     dr;
    logic [2:0]     sr1;
    logic [2:0]     sr2;
    lc3_pkg::word_t imm5_sext;
    lc3_pkg::word_t off6_sext;
    lc3_pkg::word_t off9_sext;

    lc3_pkg::word_t ra;
    lc3_pkg::word_t rb;
    lc3_pkg::word_t pcmux_out;
    lc3_pkg::word_t regfilemux_out;
    lc3_pkg::word_t marmux_out;
    lc3_pkg::word_t alumux1_out;
    lc3_pkg::word_t alumux2_out;
    lc3_pkg::word_t alu_out;

    assign opcode  = lc3_pkg::opcode_t'(ir_q[15:12]);
    assign ir_bit5 = ir_q[5];
    assign dr      = ir_q[11:9];
    assign sr1     = mdr_sel ? ir_q[11:9] : ir_q[8:6]; // store source sits in the dr field.
    assign sr2     = ir_q[2:0];

    assign imm5_sext  = {{(lc3_pkg::word_width-5){ir_q[4]}}, ir_q[4:0]};
    assign off6_sext  = {{(lc3_pkg::word_width-6){ir_q[5]}}, ir_q[5:0]};
    assign off9_sext  = {{(lc3_pkg::word_width-9){ir_q[8]}}, ir_q[8:0]};

    assign ben = |(nzp_q & ir_q[11:9]);
    assign mar = mar_q;
    assign mdr = mdr_q;

    regfile regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ld_regf (ld_regf),
        .in      (regfilemux_out),
        .dr      (dr),
        .sr1     (sr1),
        .sr2     (sr2),
        .ra      (ra),
        .rb      (rb)
    );

    alu alu_unit (
        .op (alu_op),
        .a  (alumux1_out),
        .b  (alumux2_out),
        .f  (alu_out)
    );

    always_comb begin
        case (pcmux_sel)
            lc3_pkg::pc_reg: pcmux_out = ra;
            lc3_pkg::pc_alu: pcmux_out = alu_out;
            default:         pcmux_out = pc_q + 16'd1;
        endcase

        regfilemux_out = regfilemux_sel ? mdr_q : alu_out;
        alumux1_out    = alumux1_sel ? pc_q : ra;
        marmux_out     = marmux_sel ? alu_out : pc_q;

        case (alumux2_sel)
            lc3_pkg::b_imm5:  alumux2_out = imm5_sext;
            lc3_pkg::b_off9:  alumux2_out = off9_sext;
            lc3_pkg::b_off6:  alumux2_out = off6_sext;
            default:          alumux2_out = rb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q  <= reset_vector;
            ir_q  <= '0;
            mar_q <= '0;
            mdr_q <= '0;
            nzp_q <= '0;
        end else begin
            if (ld_pc) pc_q <= pcmux_out;
            if (ld_ir) ir_q <= mdr_q;
            if (ld_mar) mar_q <= marmux_out;
            if (ld_mdr) mdr_q <= mdr_sel ? ra : mdr_in;
            if (ld_nzp) begin
                // n, z and p are mutually exclusive by construction.
                nzp_q <= {regfilemux_out[lc3_pkg::word_width-1],
                          regfilemux_out == '0,
                          !regfilemux_out[lc3_pkg::word_width-1] && regfilemux_out != '0};
            end
        end
    end

    // the condition codes follow a register write and then hold exactly one flag.
    assert property (@(posedge clk) disable iff (!rst_n)
        ld_nzp |=> $past(ld_regf) && $onehot(nzp_q));

endmodule

/* rtl/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  lc3_pkg::opcode_t    opcode,
    input  logic                ir_bit5,
    input  logic                ben,
    input  logic                wb_ack,
    output logic                ld_pc,
    output logic                ld_ir,
    output logic                ld_regf,
    output logic                ld_mdr,
    output logic                ld_mar,
    output logic                ld_nzp,
    output logic                mdr_sel,
    output lc3_pkg::pcmux_t     pcmux_sel,
    output logic                regfilemux_sel,
    output logic                marmux_sel,
    output logic                alumux1_sel,
    output lc3_pkg::alumux2_t   alumux2_sel,
    output lc3_pkg::alu_op_t    alu_op,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic                halted
);

    lc3_pkg::state_t state;
    lc3_pkg::state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lc3_pkg::s_fetch1;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lc3_pkg::s_fetch1: state_next = lc3_pkg::s_fetch2;
            lc3_pkg::s_fetch2: if (wb_ack) state_next = lc3_pkg::s_fetch3;
            lc3_pkg::s_fetch3: state_next = lc3_pkg::s_decode;
            lc3_pkg::s_decode: begin
                case (opcode)
                    lc3_pkg::op_add,
                    lc3_pkg::op_and,
                    lc3_pkg::op_not: state_next = lc3_pkg::s_alu;
                    lc3_pkg::op_lea: state_next = lc3_pkg::s_lea;
                    lc3_pkg::op_br:  state_next = lc3_pkg::s_br;
                    lc3_pkg::op_jmp: state_next = lc3_pkg::s_jmp;
                    lc3_pkg::op_ld,
                    lc3_pkg::op_ldr: state_next = lc3_pkg::s_ld_addr;
                    lc3_pkg::op_st,
                    lc3_pkg::op_str: state_next = lc3_pkg::s_st_addr;
                    default:         state_next = lc3_pkg::s_halt; // trap and unsupported codes stop.
                endcase
            end
            lc3_pkg::s_ld_addr:  state_next = lc3_pkg::s_ld_read;
            lc3_pkg::s_ld_read:  if (wb_ack) state_next = lc3_pkg::s_ld_wb;
            lc3_pkg::s_st_addr:  state_next = lc3_pkg::s_st_mdr;
            lc3_pkg::s_st_mdr:   state_next = lc3_pkg::s_st_write;
            lc3_pkg::s_st_write: if (wb_ack) state_next = lc3_pkg::s_fetch1;
            lc3_pkg::s_halt:     state_next = lc3_pkg::s_halt;
            default:             state_next = lc3_pkg::s_fetch1;
        endcase
    end

    always_comb begin
        ld_pc          = 1'b0;
        ld_ir          = 1'b0;
        ld_regf        = 1'b0;
        ld_mdr         = 1'b0;
        ld_mar         = 1'b0;
        ld_nzp         = 1'b0;
        mdr_sel        = 1'b0;
        pcmux_sel      = lc3_pkg::pc_inc;
        regfilemux_sel = 1'b0;
        marmux_sel     = 1'b0;
        alumux1_sel    = 1'b0;
        alumux2_sel    = lc3_pkg::b_reg;
        alu_op         = lc3_pkg::alu_add;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        case (state)
            lc3_pkg::s_fetch1: begin
                ld_mar = 1'b1; // mar takes the old pc while pc steps on.
                ld_pc  = 1'b1;
            end
            lc3_pkg::s_fetch2, lc3_pkg::s_ld_read: begin
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                ld_mdr = wb_ack; // capture read data only in the ack cycle.
            end
            lc3_pkg::s_fetch3: ld_ir = 1'b1;
            lc3_pkg::s_alu: begin
                ld_regf     = 1'b1;
                ld_nzp      = 1'b1;
                alumux2_sel = ir_bit5 ? lc3_pkg::b_imm5 : lc3_pkg::b_reg;
                if (opcode == lc3_pkg::op_and) alu_op = lc3_pkg::alu_and;
                else if (opcode == lc3_pkg::op_not) alu_op = lc3_pkg::alu_not;
            end
            lc3_pkg::s_lea: begin
                ld_regf     = 1'b1;
                ld_nzp      = 1'b1;
                alumux1_sel = 1'b1;
                alumux2_sel = lc3_pkg::b_off9;
            end
            lc3_pkg::s_br: begin
                ld_pc       = ben;
                pcmux_sel   = lc3_pkg::pc_alu;
                alumux1_sel = 1'b1;
                alumux2_sel = lc3_pkg::b_off9;
            end
            lc3_pkg::s_jmp: begin
                ld_pc     = 1'b1;
                pcmux_sel = lc3_pkg::pc_reg;
            end
            lc3_pkg::s_ld_addr, lc3_pkg::s_st_addr: begin
                ld_mar     = 1'b1;
                marmux_sel = 1'b1;
                if (opcode == lc3_pkg::op_ldr || opcode == lc3_pkg::op_str) begin
                    alumux2_sel = lc3_pkg::b_off6;
                end else begin
                    alumux1_sel = 1'b1;
                    alumux2_sel = lc3_pkg::b_off9;
                end
            end
            lc3_pkg::s_ld_wb: begin
                ld_regf        = 1'b1;
                ld_nzp         = 1'b1;
                regfilemux_sel = 1'b1;
            end
            lc3_pkg::s_st_mdr: begin
                ld_mdr  = 1'b1;
                mdr_sel = 1'b1;
            end
            lc3_pkg::s_st_write: begin
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_we  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign halted = (state == lc3_pkg::s_halt);

    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);

    // a stalled bus cycle holds its state, so adr, we and wdata cannot move.
    assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {lc3_pkg::s_fetch2, lc3_pkg::s_ld_read, lc3_pkg::s_st_write} && !wb_ack)
        |=> (state == $past(state)));

    assert property (@(posedge clk) disable iff (!rst_n) !(halted && wb_cyc));

endmodule

/* rtl/lc3_top.sv */
`timescale 1ns/1ps

module lc3_top #(
    parameter lc3_pkg::word_t reset_vector = 16'h3000
) (
    input  logic            clk,
    input  logic            rst_n,
    output lc3_pkg::word_t  wb_adr,
    output lc3_pkg::word_t  wb_wdata,
    input  lc3_pkg::word_t  wb_rdata,
    output logic            wb_we,
    output logic            wb_cyc,
    output logic            wb_stb,
    input  logic            wb_ack,
    output logic            halted
);

    logic                ld_pc;
    logic                ld_ir;
    logic                ld_regf;
    logic                ld_mdr;
    logic                ld_mar;
    logic                ld_nzp;
    logic                mdr_sel;
    lc3_pkg::pcmux_t     pcmux_sel;
    logic                regfilemux_sel;
    logic                marmux_sel;
    logic                alumux1_sel;
    lc3_pkg::alumux2_t   alumux2_sel;
    lc3_pkg::alu_op_t    alu_op;
    lc3_pkg::opcode_t    opcode;
    logic                ir_bit5;
    logic                ben;

    control_fsm ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode         (opcode),
        .ir_bit5        (ir_bit5),
        .ben            (ben),
        .wb_ack         (wb_ack),
        .ld_pc          (ld_pc),
        .ld_ir          (ld_ir),
        .ld_regf        (ld_regf),
        .ld_mdr         (ld_mdr),
        .ld_mar         (ld_mar),
        .ld_nzp         (ld_nzp),
        .mdr_sel        (mdr_sel),
        .pcmux_sel      (pcmux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .alumux1_sel    (alumux1_sel),
        .alumux2_sel    (alumux2_sel),
        .alu_op         (alu_op),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .halted         (halted)
    );

    datapath #(
        .reset_vector (reset_vector)
    ) dp (
        .clk            (clk),
        .rst_n          (rst_n),
        .ld_pc          (ld_pc),
        .ld_ir          (ld_ir),
        .ld_regf        (ld_regf),
        .ld_mdr         (ld_mdr),
        .ld_mar         (ld_mar),
        .ld_nzp         (ld_nzp),
        .mdr_sel        (mdr_sel),
        .pcmux_sel      (pcmux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .alumux1_sel    (alumux1_sel),
        .alumux2_sel    (alumux2_sel),
        .alu_op         (alu_op),
        .mdr_in         (wb_rdata), // read data goes straight to mdr.
        .opcode         (opcode),
        .ir_bit5        (ir_bit5),
        .ben            (ben),
        .mar            (wb_adr),
        .mdr            (wb_wdata)
    );

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge like every other input.
    end

endmodule

/* verif/tb_lc3.sv */
`timescale 1ns/1ps

module tb_lc3;

    localparam logic [15:0] reset_vector  = 16'h3000;
    localparam int          clk_period_ns = 4;
    localparam int          max_ref_steps = 2000;
    localparam logic [31:0] lfsr_seed     = 32'h990d_8b63;
    localparam string       program_file  = "verif/program.hex";

    logic        clk;
    logic        rst_n;
    logic [15:0] wb_adr;
    logic [15:0] wb_wdata;
    logic [15:0] wb_rdata;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_ack;
    logic        halted;

    logic [15:0] mem [0:65535];
    logic [15:0] ref_mem [0:65535];
    logic [15:0] ref_regs [8];
    logic [15:0] ref_halt_pc;
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [31:0] lfsr_state;
    int          ref_count;
    int          ref_stores;
    int          store_count;
    int          bus_cycles;
    bit          ref_ready;
    bit          bus_open;
    bit          halt_seen;
    logic [15:0] held_adr;
    logic [15:0] held_wdata;
    logic        held_we;

    clk_gen #(
        .period_ns (clk_period_ns)
    ) clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lc3_top #(
        .reset_vector (reset_vector)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32, 22, 2, 1.
    endfunction

    task automatic draw_wait(output logic [1:0] w);
        for (int i = 0; i < 2; i++) begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'h5aa5;
    endfunction

    task automatic check_bus_idle();
        check_value("wb_cyc", 16'(wb_cyc), 16'h0000);
        check_value("wb_stb", 16'(wb_stb), 16'h0000);
        check_value("halted", 16'(halted), 16'h0000);
    endtask

    // the instruction-set model runs to TRAP on ref_mem before the DUT starts.
    function automatic int lc3_ref_run();
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] res;
        logic [15:0] src_b;
        logic [15:0] off6;
        logic [15:0] off9;
        logic [15:0] addr;
        logic [2:0]  nzp;
        logic        write_back;
        logic        halt;
        int          count;
        pc = reset_vector;
        nzp = 3'b000;
        halt = 1'b0;
        count = 0;
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = 16'h0000;
        end
        while (!halt && count < max_ref_steps) begin
            ir = ref_mem[pc];
            pc = pc + 16'd1;
            count++;
            write_back = 1'b0;
            res = 16'h0000;
            off6 = {{10{ir[5]}}, ir[5:0]};
            off9 = {{7{ir[8]}}, ir[8:0]};
            src_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : ref_regs[ir[2:0]];
            case (ir[15:12])
                4'b0001: begin
                    res = ref_regs[ir[8:6]] + src_b; // ADD.
                    write_back = 1'b1;
                end
                4'b0101: begin
                    res = ref_regs[ir[8:6]] & src_b; // AND.
                    write_back = 1'b1;
                end
                4'b1001: begin
                    res = ~ref_regs[ir[8:6]]; // NOT.
                    write_back = 1'b1;
                end
                4'b0000: begin
                    if ((ir[11:9] & nzp) != 3'b000) pc = pc + off9;
                end
                4'b1100: pc = ref_regs[ir[8:6]];
                4'b0010: begin
                    res = ref_mem[pc + off9]; // LD.
                    write_back = 1'b1;
                end
                4'b0110: begin
                    res = ref_mem[ref_regs[ir[8:6]] + off6]; // LDR.
                    write_back = 1'b1;
                end
                4'b1110: begin
                    res = pc + off9; // LEA.
                    write_back = 1'b1;
                end
                4'b0011, 4'b0111: begin
                    addr = (ir[14]) ? ref_regs[ir[8:6]] + off6 : pc + off9;
                    ref_mem[addr] = ref_regs[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(ref_regs[ir[11:9]]);
                end
                default: halt = 1'b1;
            endcase
            if (write_back) begin
                ref_regs[ir[11:9]] = res;
                nzp = {res[15], res == 16'd0, !res[15] && res != 16'd0};
            end
        end
        ref_halt_pc = pc;
        return count;
    endfunction

    initial begin : slave_memory
        logic [1:0] wait_left;
        logic       busy;
        wb_ack <= 1'b0;
        wb_rdata <= 16'h0000;
        lfsr_state = lfsr_seed;
        busy = 1'b0;
        wait_left = 2'd0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(16'(a));
        end
        $readmemh(program_file, mem);
        forever begin
            @(posedge clk);
            if (!rst_n || wb_ack) begin
                wb_ack <= 1'b0; // ack lasts exactly one cycle.
                busy = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    draw_wait(wait_left);
                end
                if (wait_left == 2'd0) begin
                    wb_ack <= 1'b1;
                    if (wb_we) mem[wb_adr] = wb_wdata;
                    else wb_rdata <= mem[wb_adr];
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    // every write is matched at its ack edge against the next reference store.
    always @(posedge clk) begin
        if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack) begin
            if (exp_addr.size() == 0) begin
                report_failure("a store appeared after all expected stores were seen");
            end else begin
                store_count++;
                check_value("wb_adr", wb_adr, exp_addr.pop_front());
                check_value("wb_wdata", wb_wdata, exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && wb_cyc && wb_stb) begin
            if (!bus_open) begin
                bus_open = 1'b1;
                held_adr = wb_adr;
                held_wdata = wb_wdata;
                held_we = wb_we;
                if (bus_cycles == 0) check_value("wb_adr", wb_adr, reset_vector);
                bus_cycles++;
            end else begin
                check_value("wb_adr", wb_adr, held_adr);
                check_value("wb_we", 16'(wb_we), 16'(held_we));
                if (held_we) check_value("wb_wdata", wb_wdata, held_wdata);
            end
            if (wb_ack) bus_open = 1'b0;
        end
        if (rst_n && halt_seen && wb_cyc) report_failure("a bus cycle started after halt");
        if (rst_n && halted) halt_seen = 1'b1;
    end

    initial begin : watchdog
        wait (ref_ready);
        #((ref_count * 12 + 200) * clk_period_ns);
        report_failure("watchdog expired: the processor never halted");
    end

    initial begin : main_sequence
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = fill_word(16'(a));
        end
        $readmemh(program_file, ref_mem);
        ref_count = lc3_ref_run();
        ref_stores = exp_addr.size();
        if (ref_count >= max_ref_steps) report_failure("reference model never reached TRAP");
        ref_ready = 1'b1;

        @(posedge clk);
        @(negedge clk);
        check_bus_idle();
        wait (rst_n);
        @(negedge clk);
        check_bus_idle();

        wait (halted);
        repeat (10) @(posedge clk); // the bus must stay quiet after halt.
        check_value("halted", 16'(halted), 16'h0001);
        check_value("store count", 16'(store_count), 16'(ref_stores));
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("R%0d", i), UUT.dp.regs.regs[i], ref_regs[i]);
        end
        check_value("pc", UUT.dp.pc_q, ref_halt_pc);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verif/program.hex */
// one 16-bit word per line in hex, an @ line sets the word address.
// the comment after each word gives its address and instruction.
@3000
2227 // 3000 LD   R1, x3028
2427 // 3001 LD   R2, x3029
1642 // 3002 ADD  R3, R1, R2
586D // 3003 AND  R4, R1, #13
5A42 // 3004 AND  R5, R1, R2
EC3A // 3005 LEA  R6, x3040
9EFF // 3006 NOT  R7, R3
1139 // 3007 ADD  R0, R4, #-7
7780 // 3008 STR  R3, R6, #0
79BE // 3009 STR  R4, R6, #-2
7F85 // 300A STR  R7, R6, #5
301F // 300B ST   R0, x302B
63BE // 300C LDR  R1, R6, #-2
0801 // 300D BRn  x300F (not taken)
1261 // 300E ADD  R1, R1, #1
0201 // 300F BRp  x3011 (taken)
1268 // 3010 ADD  R1, R1, #8
54A0 // 3011 AND  R2, R2, #0
0A01 // 3012 BRnp x3014 (not taken)
0401 // 3013 BRz  x3015 (taken)
927F // 3014 NOT  R1, R1
7381 // 3015 STR  R1, R6, #1
2A14 // 3016 LD   R5, x302B
0601 // 3017 BRzp x3019 (not taken)
E403 // 3018 LEA  R2, x301C
C080 // 3019 JMP  R2
F025 // 301A TRAP x25
F025 // 301B TRAP x25
7BBF // 301C STR  R5, R6, #-1
1021 // 301D ADD  R0, R0, #1
09FE // 301E BRn  x301D
7182 // 301F STR  R0, R6, #2
F025 // 3020 TRAP x25
@3028
1234 // 3028 data
8001 // 3029 data

/* lc3_core.f */
common/lc3_pkg.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
rtl/control_fsm.sv
rtl/lc3_top.sv
verif/clk_gen.sv
verif/tb_lc3.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lc3 -f lc3_core.f &&
./obj_dir/Vtb_lc3 | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
